// ==== logic/plic_pkg.sv ====
// PLIC shared definitions
package plic_pkg;

    // bus geometry
    localparam int ADDR_BITS = 22;
    localparam int DATA_BITS = 64;
    localparam int STRB_BITS = 8;

    // priority, threshold and claim id widths
    localparam int PRIO_BITS = 4;
    localparam int ID_BITS   = 10;

    // region codes taken from address bits 21:12
    localparam logic [9:0] REGION_PRIO    = 10'h000;  // 0x000000 source priorities
    localparam logic [9:0] REGION_PENDING = 10'h001;  // 0x001000 pending bits
    localparam logic [9:0] REGION_ENABLE  = 10'h002;  // 0x002000 enables with 0x80 per context

    // first context control page with pages 0x1000 apart
    localparam logic [9:0] REGION_CTX_BASE = 10'h200;

    // one 64-bit word of a context control page
    // threshold in the low half and claim id in the high half
    typedef union packed {
        logic [DATA_BITS-1:0] raw;            // bus view
        struct packed {
            logic [21:0]          rsvd_hi;
            logic [ID_BITS-1:0]   claim_id;   // bits 41:32
            logic [27:0]          rsvd_lo;
            logic [PRIO_BITS-1:0] thresh;     // bits 3:0
        } f;                                  // decoded view
    } plic_ctx_word_u;

endpackage

// ==== logic/plic_gateway.sv ====
// PLIC interrupt gateway
module plic_gateway #(
    parameter int IRQ_NUM = 32
) (
    input  logic                                   i_clk,
    input  logic                                   i_nrst,
    input  logic [IRQ_NUM-1:0]                     i_irq,
    input  logic [IRQ_NUM*plic_pkg::PRIO_BITS-1:0] i_src_prio,
    input  logic                                   i_claim_valid,
    input  logic [plic_pkg::ID_BITS-1:0]           i_claim_id,
    output logic [IRQ_NUM-1:0]                     o_pending
);

    localparam int PW = plic_pkg::PRIO_BITS;

    logic [IRQ_NUM-1:0] set_req;   // level request with a live priority
    logic [IRQ_NUM-1:0] clr_req;   // claim decoded to one-hot

    always_comb begin
        set_req = '0;
        clr_req = '0;
        // source 0 is reserved and never pends
        for (int s = 1; s < IRQ_NUM; s++) begin
            set_req[s] = i_irq[s] && (i_src_prio[s*PW +: PW] != '0);
            clr_req[s] = i_claim_valid && (int'(i_claim_id) == s);
        end
    end

    // set beats clear, so a level still held re-pends at once
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_pending <= '0;
        end else begin
            o_pending <= (o_pending & ~clr_req) | set_req;
        end
    end

endmodule

// ==== logic/plic_reg_decode.sv ====
// PLIC register decoder
module plic_reg_decode #(
    parameter int IRQ_NUM = 32,
    parameter int CTX_NUM = 2
) (
    input  logic                                      i_clk,
    input  logic                                      i_nrst,
    input  logic                                      i_req_valid,
    input  logic                                      i_req_write,
    input  logic [plic_pkg::ADDR_BITS-1:0]            i_req_addr,
    input  logic [plic_pkg::DATA_BITS-1:0]            i_req_wdata,
    input  logic [plic_pkg::STRB_BITS-1:0]            i_req_wstrb,
    input  logic [IRQ_NUM-1:0]                        i_pending,
    input  logic [CTX_NUM*plic_pkg::ID_BITS-1:0]      i_ctx_claim_id,
    output logic                                      o_resp_valid,
    output logic [plic_pkg::DATA_BITS-1:0]            o_resp_rdata,
    output logic [IRQ_NUM*plic_pkg::PRIO_BITS-1:0]    o_src_prio,
    output logic [CTX_NUM*IRQ_NUM-1:0]                o_ie,
    output logic [CTX_NUM*plic_pkg::PRIO_BITS-1:0]    o_thresh,
    output logic                                      o_claim_valid,
    output logic [plic_pkg::ID_BITS-1:0]              o_claim_id
);

    localparam int PW  = plic_pkg::PRIO_BITS;
    localparam int IDW = plic_pkg::ID_BITS;

    logic [9:0]                     region;
    logic [8:0]                     word_idx;   // 64-bit word within a page
    logic [4:0]                     ie_ctx;     // enable block, 0x80 each
    logic [8:0]                     ctx_page;   // context control page
    logic                           hit_prio;
    logic                           hit_pend;
    logic                           hit_ie;
    logic                           hit_ctx;
    logic                           wr_en;
    logic                           lo_strb;
    logic                           hi_strb;
    plic_pkg::plic_ctx_word_u       ctx_rd;
    plic_pkg::plic_ctx_word_u       ctx_wr;
    logic [plic_pkg::DATA_BITS-1:0] rdata_next;

    assign region   = i_req_addr[21:12];
    assign word_idx = i_req_addr[11:3];
    assign ie_ctx   = i_req_addr[11:7];
    assign ctx_page = i_req_addr[20:12];

    assign hit_prio = (region == plic_pkg::REGION_PRIO);
    assign hit_pend = (region == plic_pkg::REGION_PENDING) && (word_idx == 9'd0);
    assign hit_ie   = (region == plic_pkg::REGION_ENABLE) && (int'(ie_ctx) < CTX_NUM)
                      && (i_req_addr[6:3] == 4'd0);
    assign hit_ctx  = (region >= plic_pkg::REGION_CTX_BASE) && (int'(ctx_page) < CTX_NUM)
                      && (word_idx == 9'd0);

    assign wr_en   = i_req_valid && i_req_write;
    assign lo_strb = |i_req_wstrb[3:0];
    assign hi_strb = |i_req_wstrb[7:4];

    assign ctx_wr.raw = i_req_wdata;

    // read data mux, the old value also goes back on writes
    always_comb begin
        rdata_next = '0;
        ctx_rd.raw = '0;
        if (hit_prio) begin
            // two sources per word, source 0 slot stays zero
            for (int s = 1; s < IRQ_NUM; s++) begin
                if ((s / 2) == int'(word_idx)) begin
                    if ((s % 2) == 1) begin
                        rdata_next[35:32] = o_src_prio[s*PW +: PW];
                    end else begin
                        rdata_next[3:0] = o_src_prio[s*PW +: PW];
                    end
                end
            end
        end else if (hit_pend) begin
            rdata_next[IRQ_NUM-1:0] = i_pending;
        end else if (hit_ie) begin
            for (int c = 0; c < CTX_NUM; c++) begin
                if (c == int'(ie_ctx)) begin
                    rdata_next[IRQ_NUM-1:0] = o_ie[c*IRQ_NUM +: IRQ_NUM];
                end
            end
        end else if (hit_ctx) begin
            for (int c = 0; c < CTX_NUM; c++) begin
                if (c == int'(ctx_page)) begin
                    ctx_rd.f.thresh   = o_thresh[c*PW +: PW];
                    ctx_rd.f.claim_id = i_ctx_claim_id[c*IDW +: IDW];
                end
            end
            rdata_next = ctx_rd.raw;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_resp_valid  <= 1'b0;
            o_resp_rdata  <= '0;
            o_src_prio    <= '0;
            o_ie          <= '0;
            o_thresh      <= '0;
            o_claim_valid <= 1'b0;
            o_claim_id    <= '0;
        end else begin
            o_resp_valid  <= i_req_valid;  // fixed one-cycle response
            // reading a control word with a live id claims it
            o_claim_valid <= i_req_valid && !i_req_write && hit_ctx
                             && (ctx_rd.f.claim_id != '0);
            if (i_req_valid) begin
                o_resp_rdata <= rdata_next;
                o_claim_id   <= ctx_rd.f.claim_id;
            end

            if (wr_en && hit_prio) begin
                for (int s = 1; s < IRQ_NUM; s++) begin
                    if ((s / 2) == int'(word_idx)) begin
                        if ((s % 2) == 1) begin
                            if (hi_strb) begin
                                o_src_prio[s*PW +: PW] <= i_req_wdata[35:32];
                            end
                        end else if (lo_strb) begin
                            o_src_prio[s*PW +: PW] <= i_req_wdata[3:0];
                        end
                    end
                end
            end

            if (wr_en && hit_ie) begin
                for (int c = 0; c < CTX_NUM; c++) begin
                    for (int b = 0; b < IRQ_NUM; b++) begin
                        if ((c == int'(ie_ctx)) && ((b < 32) ? lo_strb : hi_strb)) begin
                            o_ie[c*IRQ_NUM + b] <= i_req_wdata[b];
                        end
                    end
                end
            end

            // high half of the control word is claim/complete, writes ignored
            if (wr_en && hit_ctx && lo_strb) begin
                for (int c = 0; c < CTX_NUM; c++) begin
                    if (c == int'(ctx_page)) begin
                        o_thresh[c*PW +: PW] <= ctx_wr.f.thresh;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/plic_target.sv ====
// PLIC per-context target pipeline
module plic_target #(
    parameter int IRQ_NUM = 32,
    parameter int CTX_NUM = 2
) (
    input  logic                                   i_clk,
    input  logic                                   i_nrst,
    input  logic [IRQ_NUM-1:0]                     i_pending,
    input  logic [IRQ_NUM*plic_pkg::PRIO_BITS-1:0] i_src_prio,
    input  logic [CTX_NUM*IRQ_NUM-1:0]             i_ie,
    input  logic [CTX_NUM*plic_pkg::PRIO_BITS-1:0] i_thresh,
    output logic [CTX_NUM*plic_pkg::ID_BITS-1:0]   o_ctx_claim_id,
    output logic [CTX_NUM-1:0]                     o_ip
);

    localparam int PW     = plic_pkg::PRIO_BITS;
    localparam int IDW    = plic_pkg::ID_BITS;
    localparam int LEVELS = 1 << PW;

    for (genvar c = 0; c < CTX_NUM; c++) begin : g_ctx
        logic [PW-1:0]         thresh;
        logic [IRQ_NUM*PW-1:0] elig_prio;
        logic [LEVELS-1:0]     elig_mask;
        logic [PW-1:0]         top_level;
        logic [IDW-1:0]        sel_id;

        logic [IRQ_NUM*PW-1:0] s1_prio;    // stage 1 eligible priorities
        logic [LEVELS-1:0]     s1_mask;    // stage 1 levels present
        logic [IRQ_NUM*PW-1:0] s2_prio;    // stage 1 data kept in step with the level
        logic [PW-1:0]         s2_level;   // stage 2 winning level
        logic [IDW-1:0]        s3_id;
        logic                  s3_ip;

        assign thresh = i_thresh[c*PW +: PW];

        // stage 1: pending, enabled and strictly above threshold
        always_comb begin
            elig_prio = '0;
            elig_mask = '0;
            for (int s = 1; s < IRQ_NUM; s++) begin
                if (i_pending[s] && i_ie[c*IRQ_NUM + s]
                        && (i_src_prio[s*PW +: PW] > thresh)) begin
                    elig_prio[s*PW +: PW] = i_src_prio[s*PW +: PW];
                    elig_mask[i_src_prio[s*PW +: PW]] = 1'b1;
                end
            end
        end

        // stage 2: highest level with any eligible source
        always_comb begin
            top_level = '0;
            for (int l = 1; l < LEVELS; l++) begin
                if (s1_mask[l]) begin
                    top_level = l[PW-1:0];
                end
            end
        end

        // stage 3: scan downwards so the lowest id wins a tie
        always_comb begin
            sel_id = '0;
            for (int s = IRQ_NUM - 1; s >= 1; s--) begin
                if ((s2_level != '0) && (s2_prio[s*PW +: PW] == s2_level)) begin
                    sel_id = s[IDW-1:0];
                end
            end
        end

        always_ff @(posedge i_clk or negedge i_nrst) begin
            if (!i_nrst) begin
                s1_prio  <= '0;
                s1_mask  <= '0;
                s2_prio  <= '0;
                s2_level <= '0;
                s3_id    <= '0;
                s3_ip    <= 1'b0;
            end else begin
                s1_prio  <= elig_prio;
                s1_mask  <= elig_mask;
                s2_prio  <= s1_prio;
                s2_level <= top_level;
                s3_id    <= sel_id;
                s3_ip    <= (sel_id != '0);  // id 0 means nothing to serve
            end
        end

        assign o_ctx_claim_id[c*IDW +: IDW] = s3_id;
        assign o_ip[c]                      = s3_ip;
    end

endmodule

// ==== logic/plic_top.sv ====
// PLIC top level
module plic_top #(
    parameter int IRQ_NUM = 32,   // sources including reserved 0, 2 to 64
    parameter int CTX_NUM = 2     // contexts, 1 to 8
) (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_req_valid,
    input  logic                           i_req_write,
    input  logic [plic_pkg::ADDR_BITS-1:0] i_req_addr,
    input  logic [plic_pkg::DATA_BITS-1:0] i_req_wdata,
    input  logic [plic_pkg::STRB_BITS-1:0] i_req_wstrb,
    input  logic [IRQ_NUM-1:0]             i_irq,
    output logic                           o_resp_valid,
    output logic [plic_pkg::DATA_BITS-1:0] o_resp_rdata,
    output logic [CTX_NUM-1:0]             o_ip
);

    logic [IRQ_NUM*plic_pkg::PRIO_BITS-1:0] r_src_prio;
    logic [CTX_NUM*IRQ_NUM-1:0]             r_ie;
    logic [CTX_NUM*plic_pkg::PRIO_BITS-1:0] r_thresh;
    logic [IRQ_NUM-1:0]                     r_pending;
    logic [CTX_NUM*plic_pkg::ID_BITS-1:0]   ctx_claim_id;  // current winner per context
    logic                                   claim_valid;
    logic [plic_pkg::ID_BITS-1:0]           claim_id;

    plic_reg_decode #(
        .IRQ_NUM(IRQ_NUM),
        .CTX_NUM(CTX_NUM)
    ) u_decode (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_req_valid    (i_req_valid),
        .i_req_write    (i_req_write),
        .i_req_addr     (i_req_addr),
        .i_req_wdata    (i_req_wdata),
        .i_req_wstrb    (i_req_wstrb),
        .i_pending      (r_pending),
        .i_ctx_claim_id (ctx_claim_id),
        .o_resp_valid   (o_resp_valid),
        .o_resp_rdata   (o_resp_rdata),
        .o_src_prio     (r_src_prio),
        .o_ie           (r_ie),
        .o_thresh       (r_thresh),
        .o_claim_valid  (claim_valid),
        .o_claim_id     (claim_id)
    );

    plic_gateway #(
        .IRQ_NUM(IRQ_NUM)
    ) u_gateway (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_irq         (i_irq),
        .i_src_prio    (r_src_prio),
        .i_claim_valid (claim_valid),
        .i_claim_id    (claim_id),
        .o_pending     (r_pending)
    );

    plic_target #(
        .IRQ_NUM(IRQ_NUM),
        .CTX_NUM(CTX_NUM)
    ) u_target (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_pending      (r_pending),
        .i_src_prio     (r_src_prio),
        .i_ie           (r_ie),
        .i_thresh       (r_thresh),
        .o_ctx_claim_id (ctx_claim_id),
        .o_ip           (o_ip)
    );

endmodule

// ==== testbench/plic_tests.svh ====
// PLIC directed tests
`ifndef PLIC_TESTS_SVH
`define PLIC_TESTS_SVH

localparam addr_t PEND_ADDR = 22'h001000;
localparam int    ARB_SRCS  = 8;

int arb_src[ARB_SRCS];
int arb_prio[ARB_SRCS];
bit arb_done[ARB_SRCS];

task automatic read_expect(input string name, input addr_t addr, input data_t expected);
    data_t data;
    bus_read(addr, data);
    check_equal(name, expected, data);
endtask

// odd sources live in bits 35:32, even ones in bits 3:0
task automatic set_prio(input int src, input int prio);
    data_t      data;
    logic [7:0] strb;
    if ((src % 2) == 1) begin
        data = data_t'(prio) << 32;
        strb = 8'hF0;
    end else begin
        data = data_t'(prio);
        strb = 8'h0F;
    end
    bus_write(addr_t'((src / 2) * 8), data, strb);
endtask

task automatic set_enable(input int ctx, input data_t mask);
    bus_write(addr_t'(32'h2000 + ctx * 32'h80), mask, 8'hFF);
endtask

task automatic set_thresh(input int ctx, input int level);
    bus_write(addr_t'(32'h200000 + ctx * 32'h1000), data_t'(level), 8'h0F);
endtask

task automatic claim_read(input int ctx, output int id);
    data_t data;
    bus_read(addr_t'(32'h200000 + ctx * 32'h1000), data);
    id = int'(data[41:32]);
endtask

task automatic wait_ip(input int ctx, input logic level);
    int n;
    n = 0;
    while ((o_ip[ctx] !== level) && (n < IP_TIMEOUT)) begin
        @(negedge i_clk);
        n++;
    end
    if (o_ip[ctx] !== level) begin
        stop_on_error($sformatf("o_ip[%0d] did not reach %0b within %0d cycles",
                                ctx, level, IP_TIMEOUT));
    end
endtask

task automatic hold_ip_low(input string name, input int cycles);
    for (int n = 0; n < cycles; n++) begin
        @(negedge i_clk);
        check_equal(name, 64'd0, data_t'(o_ip));
    end
endtask

// give a claim time to clear pending and pass the target stages
task automatic pipe_settle();
    repeat (PIPE_CYCLES) @(negedge i_clk);
endtask

// highest priority first, lowest source id on a tie
function automatic int next_winner();
    int best;
    best = -1;
    for (int k = 0; k < ARB_SRCS; k++) begin
        if (!arb_done[k] && ((best < 0) || (arb_prio[k] > arb_prio[best])
                || ((arb_prio[k] == arb_prio[best]) && (arb_src[k] < arb_src[best])))) begin
            best = k;
        end
    end
    return best;
endfunction

task automatic reg_readback();
    string name;
    name = "reg_readback";
    read_expect(name, 22'h000008, 64'd0);
    read_expect(name, PEND_ADDR, 64'd0);
    read_expect(name, 22'h002000, 64'd0);
    read_expect(name, 22'h002080, 64'd0);
    read_expect(name, 22'h200000, 64'd0);
    read_expect(name, 22'h201000, 64'd0);
    bus_write(22'h000008, 64'hABCD_0009_1234_5676, 8'hFF);  // sources 2 and 3
    read_expect(name, 22'h000008, 64'h0000_0009_0000_0006);
    bus_write(22'h000008, 64'h0000_000C_0000_0001, 8'h0F);  // low half only
    read_expect(name, 22'h000008, 64'h0000_0009_0000_0001);
    bus_write(22'h000000, 64'h0000_0005_0000_0007, 8'hFF);  // source 0 slot ignored
    read_expect(name, 22'h000000, 64'h0000_0005_0000_0000);
    bus_write(22'h002000, 64'h0000_0000_8000_0006, 8'hFF);
    read_expect(name, 22'h002000, 64'h0000_0000_8000_0006);
    bus_write(22'h002080, 64'h0000_0000_0001_0010, 8'hFF);
    read_expect(name, 22'h002080, 64'h0000_0000_0001_0010);
    bus_write(22'h200000, 64'h0000_0000_0000_0003, 8'hFF);
    read_expect(name, 22'h200000, 64'h0000_0000_0000_0003);
    bus_write(22'h201000, 64'h0000_03FF_0000_000A, 8'hFF);  // claim half has no effect
    read_expect(name, 22'h201000, 64'h0000_0000_0000_000A);
    read_expect(name, 22'h100000, 64'd0);  // unmapped
    read_expect(name, 22'h001008, 64'd0);
    read_expect(name, 22'h002008, 64'd0);
    read_expect(name, 22'h200008, 64'd0);
    read_expect(name, 22'h202000, 64'd0);  // no third context
    bus_write(22'h000000, 64'd0, 8'hFF);
    bus_write(22'h000008, 64'd0, 8'hFF);
    set_enable(0, 64'd0);
    set_enable(1, 64'd0);
    set_thresh(0, 0);
    set_thresh(1, 0);
endtask

task automatic single_source_claim();
    string name;
    int    id;
    name = "single_source_claim";
    set_prio(5, 3);
    set_enable(0, 64'd1 << 5);
    i_irq[5] = 1'b1;
    wait_ip(0, 1'b1);
    read_expect(name, PEND_ADDR, 64'd1 << 5);
    i_irq[5] = 1'b0;
    claim_read(0, id);
    check_equal(name, 64'd5, data_t'(id));
    wait_ip(0, 1'b0);
    read_expect(name, PEND_ADDR, 64'd0);
    set_enable(0, 64'd0);
    set_prio(5, 0);
endtask

task automatic priority_arbitration();
    string       name;
    logic [31:0] used;
    int          cand;
    int          pick;
    int          id;
    name = "priority_arbitration";
    used = '0;
    for (int k = 0; k < ARB_SRCS; k++) begin
        cand = int'($urandom_range(31, 1));
        while (used[cand]) begin
            cand = (cand % 31) + 1;  // step to the next free source
        end
        used[cand]  = 1'b1;
        arb_src[k]  = cand;
        arb_prio[k] = int'($urandom_range(15, 1));
        arb_done[k] = 1'b0;
        set_prio(cand, arb_prio[k]);
    end
    set_enable(0, data_t'(used));
    i_irq = used;
    wait_ip(0, 1'b1);
    i_irq = '0;  // pending bits stay latched
    pipe_settle();
    for (int k = 0; k < ARB_SRCS; k++) begin
        pick = next_winner();
        claim_read(0, id);
        check_equal(name, data_t'(arb_src[pick]), data_t'(id));
        arb_done[pick] = 1'b1;
        pipe_settle();
    end
    wait_ip(0, 1'b0);
    read_expect(name, 22'h200000, 64'd0);
    for (int k = 0; k < ARB_SRCS; k++) begin
        set_prio(arb_src[k], 0);
    end
    set_enable(0, 64'd0);
endtask

task automatic interrupt_masking();
    string name;
    int    id;
    name = "interrupt_masking";
    // priority equal to threshold is masked
    set_prio(7, 2);
    set_thresh(0, 2);
    set_enable(0, 64'd1 << 7);
    i_irq[7] = 1'b1;
    hold_ip_low(name, 20);
    read_expect(name, PEND_ADDR, 64'd1 << 7);
    i_irq[7] = 1'b0;
    set_thresh(0, 1);
    wait_ip(0, 1'b1);
    claim_read(0, id);
    check_equal(name, 64'd7, data_t'(id));
    wait_ip(0, 1'b0);
    set_thresh(0, 0);
    set_prio(7, 0);
    // pending but enabled nowhere
    set_prio(9, 5);
    set_enable(0, 64'd0);
    i_irq[9] = 1'b1;
    hold_ip_low(name, 20);
    i_irq[9] = 1'b0;
    set_prio(9, 0);
    // zero priority never pends
    set_enable(0, 64'd1 << 11);
    i_irq[11] = 1'b1;
    hold_ip_low(name, 20);
    read_expect(name, PEND_ADDR, 64'd1 << 9);
    i_irq[11] = 1'b0;
    set_enable(0, 64'd0);
endtask

task automatic context_isolation();
    string name;
    int    id;
    name = "context_isolation";
    set_prio(12, 4);
    set_prio(13, 6);  // shares a word with source 12
    set_enable(1, 64'd1 << 12);
    set_enable(0, 64'd1 << 13);
    i_irq[12] = 1'b1;
    wait_ip(1, 1'b1);
    check_equal(name, 64'd0, data_t'(o_ip[0]));
    i_irq[13] = 1'b1;
    wait_ip(0, 1'b1);
    i_irq[12] = 1'b0;
    i_irq[13] = 1'b0;
    claim_read(1, id);
    check_equal(name, 64'd12, data_t'(id));
    wait_ip(1, 1'b0);
    check_equal(name, 64'd1, data_t'(o_ip[0]));
    read_expect(name, PEND_ADDR, (64'd1 << 13) | (64'd1 << 9));
    claim_read(0, id);
    check_equal(name, 64'd13, data_t'(id));
    wait_ip(0, 1'b0);
    set_enable(0, 64'd0);
    set_enable(1, 64'd0);
    set_prio(12, 0);
    set_prio(13, 0);
endtask

`endif

// ==== testbench/plic_tb.sv ====
// PLIC testbench
module plic_tb;
    timeunit 1ns;
    timeprecision 10ps;

    localparam int IRQ_NUM      = 32;
    localparam int CTX_NUM      = 2;
    localparam int RESP_TIMEOUT = 10;   // cycles to wait for o_resp_valid
    localparam int IP_TIMEOUT   = 50;   // cycles to wait for an o_ip level
    localparam int PIPE_CYCLES  = 5;    // claim clear plus three target stages

    typedef logic [plic_pkg::ADDR_BITS-1:0] addr_t;
    typedef logic [plic_pkg::DATA_BITS-1:0] data_t;

    logic                          i_clk;
    logic                          i_nrst;
    logic                          i_req_valid;
    logic                          i_req_write;
    addr_t                         i_req_addr;
    data_t                         i_req_wdata;
    logic [plic_pkg::STRB_BITS-1:0] i_req_wstrb;
    logic [IRQ_NUM-1:0]            i_irq;
    logic                          o_resp_valid;
    data_t                         o_resp_rdata;
    logic [CTX_NUM-1:0]            o_ip;

    plic_top #(
        .IRQ_NUM(IRQ_NUM),
        .CTX_NUM(CTX_NUM)
    ) UUT (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req_write  (i_req_write),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_req_wstrb  (i_req_wstrb),
        .i_irq        (i_irq),
        .o_resp_valid (o_resp_valid),
        .o_resp_rdata (o_resp_rdata),
        .o_ip         (o_ip)
    );

    always #4 i_clk = ~i_clk;  // 8 ns period

    task automatic stop_on_error(input string msg);
        $display("ERROR: %s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected 0x%h, actual 0x%h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    // called on a falling edge and returns on the falling edge of the response cycle
    task automatic wait_resp();
        int n;
        n = 0;
        while (!o_resp_valid && (n < RESP_TIMEOUT)) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_resp_valid) begin
            stop_on_error("bus response never arrived");
        end
    endtask

    task automatic bus_write(input addr_t addr, input data_t data, input logic [7:0] strb);
        i_req_valid = 1'b1;
        i_req_write = 1'b1;
        i_req_addr  = addr;
        i_req_wdata = data;
        i_req_wstrb = strb;
        @(negedge i_clk);
        i_req_valid = 1'b0;  // one-cycle strobe
        i_req_write = 1'b0;
        wait_resp();
    endtask

    task automatic bus_read(input addr_t addr, output data_t data);
        i_req_valid = 1'b1;
        i_req_write = 1'b0;
        i_req_addr  = addr;
        @(negedge i_clk);
        i_req_valid = 1'b0;
        wait_resp();
        data = o_resp_rdata;
    endtask

    `include "plic_tests.svh"

    initial begin
        void'($urandom(32'h321ec792));
        i_clk       = 1'b0;
        i_nrst      = 1'b0;
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_req_wstrb = '0;
        i_irq       = '0;
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;
        @(negedge i_clk);

        reg_readback();
        single_source_claim();
        priority_arbitration();
        interrupt_masking();
        context_isolation();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+testbench
logic/plic_pkg.sv
logic/plic_gateway.sv
logic/plic_reg_decode.sv
logic/plic_target.sv
logic/plic_top.sv
testbench/plic_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing
TOP       = plic_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

SOURCES = $(wildcard logic/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
